// File: logic/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Cache geometry.
`define DC_SETS 8
`define DC_WAYS 4

// Age counter per way, wide enough for four ways.
`define DC_AGE_W 2

// Address split: tag, set index, byte offset in line.
`define DC_INDEX_W 3
`define DC_OFFSET_W 5
`define DC_TAG_W 24

// Line size and burst beats.
`define DC_LINE_W 256
`define DC_BEATS 8

`endif

// File: logic/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

	// Controller FSM states.
	typedef enum logic [2:0] {
		idle            = 3'd0,
		lookup_done     = 3'd1,
		write_back_req  = 3'd2,
		write_back_data = 3'd3,
		refill_req      = 3'd4,
		refill_data     = 3'd5,
		fill            = 3'd6,
		respond         = 3'd7
	} cache_state_e;

	// CPU request opcode.
	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} cpu_op_e;

	// CPU byte address, word aligned by the CPU.
	typedef struct packed {
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_INDEX_W-1:0]  index;
		logic [`DC_OFFSET_W-3:0] word;
		logic [1:0]              offset;
	} cpu_addr_t;

	// One CPU request.
	typedef struct packed {
		cpu_op_e     op;
		cpu_addr_t   addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} cpu_req_t;

	typedef logic [`DC_LINE_W-1:0] line_t;

	// Burst request, always line aligned.
	typedef struct packed {
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_INDEX_W-1:0]  index;
		logic [`DC_OFFSET_W-1:0] offset;
	} mem_req_t;

	// One-hot way select.
	typedef logic [`DC_WAYS-1:0] way_sel_t;

endpackage

// File: logic/line_buffer.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module line_buffer (
	input  logic              clk,
	input  logic              rst,
	input  dcache_pkg::line_t load_line,
	input  logic              buf_load,
	input  logic              shift_in,
	input  logic [31:0]       in_word,
	input  logic              shift_out,
	output dcache_pkg::line_t line,
	output logic [31:0]       out_word,
	output logic              beat_last
);

	localparam int CNT_W = `DC_OFFSET_W - 2;

	logic [CNT_W-1:0] beat_cnt;

	// --------------------
	// Line register.
	// Beats enter at the top, so the first beat lands in word 0.
	always_ff @(posedge clk) begin
		if (buf_load)
			line <= load_line;
		else if (shift_in)
			line <= {in_word, line[`DC_LINE_W-1:32]};
	end

	// Beat counter, shared by refill and write-back.
	// Eight beats wrap it back to zero.
	always_ff @(posedge clk) begin
		if (rst)
			beat_cnt <= '0;
		else if (buf_load)
			beat_cnt <= '0;
		else if (shift_in || shift_out)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// --------------------
	// Outgoing word picked by the counter.
	assign out_word  = line[{beat_cnt, 5'd0} +: 32];
	assign beat_last = (beat_cnt == CNT_W'(`DC_BEATS - 1));

endmodule

// File: logic/dcache_ways.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ways (
	input  logic                 clk,
	input  logic                 rst,
	input  dcache_pkg::cpu_req_t req,
	input  logic                 lookup_en,
	input  logic                 write_hit_en,
	input  logic                 fill_en,
	input  dcache_pkg::line_t    fill_line,
	output dcache_pkg::way_sel_t hit,
	output logic                 victim_dirty,
	output logic [`DC_TAG_W-1:0] victim_tag,
	output logic [31:0]          hit_word,
	output logic [31:0]          merged_word,
	output dcache_pkg::line_t    sel_line
);

	localparam logic [`DC_AGE_W-1:0] AGE_OLDEST = '1;

	// Register arrays, read combinationally.
	logic [`DC_TAG_W-1:0] tag_arr  [`DC_SETS][`DC_WAYS];
	dcache_pkg::line_t    data_arr [`DC_SETS][`DC_WAYS];
	logic [`DC_AGE_W-1:0] age_arr  [`DC_SETS][`DC_WAYS];
	dcache_pkg::way_sel_t valid_arr [`DC_SETS];
	dcache_pkg::way_sel_t dirty_arr [`DC_SETS];

	logic [`DC_INDEX_W-1:0]  idx;
	logic [`DC_OFFSET_W+2:0] word_pos;
	dcache_pkg::way_sel_t    victim;
	dcache_pkg::way_sel_t    target;
	logic [`DC_AGE_W-1:0]    target_age;
	logic [31:0]             fill_word;
	logic [31:0]             hit_merged;
	dcache_pkg::line_t       hit_line_new;
	dcache_pkg::line_t       fill_line_new;
	logic                    is_write;
	logic                    touch;

	// Byte-strobe merge of one word.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	assign idx      = req.addr.index;
	assign word_pos = {req.addr.word, 5'd0};
	assign is_write = (req.op == dcache_pkg::op_write);

	// --------------------
	// Tag compare per way.
	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++)
			hit[w] = valid_arr[idx][w] && (tag_arr[idx][w] == req.addr.tag);
	end

	// Lowest-numbered oldest way, scanned high to low.
	always_comb begin
		victim = '0;
		for (int w = `DC_WAYS - 1; w >= 0; w--) begin
			if (age_arr[idx][w] == AGE_OLDEST) begin
				victim    = '0;
				victim[w] = 1'b1;
			end
		end
	end

	assign target = (|hit) ? hit : victim;

	// Line, age and victim tag of the selected ways.
	always_comb begin
		sel_line   = '0;
		target_age = '0;
		victim_tag = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (target[w]) begin
				sel_line   = data_arr[idx][w];
				target_age = age_arr[idx][w];
			end
			if (victim[w])
				victim_tag = tag_arr[idx][w];
		end
	end

	assign victim_dirty = |(dirty_arr[idx] & victim);

	// Word merges for write hit and refill.
	assign hit_word    = sel_line[word_pos +: 32];
	assign hit_merged  = merge_bytes(hit_word, req.wdata, req.strb);
	assign fill_word   = fill_line[word_pos +: 32];
	assign merged_word = is_write ? merge_bytes(fill_word, req.wdata, req.strb) : fill_word;

	always_comb begin
		hit_line_new                  = sel_line;
		hit_line_new[word_pos +: 32]  = hit_merged;
		fill_line_new                 = fill_line;
		fill_line_new[word_pos +: 32] = merged_word;
	end

	// --------------------
	// Data and tag writes.
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (write_hit_en && hit[w]) begin
				data_arr[idx][w] <= hit_line_new;
			end else if (fill_en && victim[w]) begin
				data_arr[idx][w] <= fill_line_new;
				tag_arr[idx][w]  <= req.addr.tag;
			end
		end
	end

	// Hits age at lookup. Misses age at fill, so the victim holds until then.
	assign touch = (lookup_en && |hit) || fill_en;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				valid_arr[s] <= '0;
				dirty_arr[s] <= '0;
				for (int w = 0; w < `DC_WAYS; w++)
					age_arr[s][w] <= `DC_AGE_W'(w);
			end
		end else begin
			if (write_hit_en)
				dirty_arr[idx] <= dirty_arr[idx] | hit;
			if (fill_en) begin
				valid_arr[idx] <= valid_arr[idx] | victim;
				if (is_write)
					dirty_arr[idx] <= dirty_arr[idx] | victim;
				else
					dirty_arr[idx] <= dirty_arr[idx] & ~victim;
			end
			if (touch) begin
				for (int w = 0; w < `DC_WAYS; w++) begin
					if (target[w])
						age_arr[idx][w] <= '0;
					else if (age_arr[idx][w] < target_age)
						age_arr[idx][w] <= age_arr[idx][w] + 1'b1;
				end
			end
		end
	end

	// At most one way matches a looked-up tag.
	assert property (@(posedge clk) disable iff (rst)
		lookup_en |-> $onehot0(hit));

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl (
	input  logic                 clk,
	input  logic                 rst,

	input  dcache_pkg::cpu_req_t cpu_req,
	input  logic                 cpu_req_valid,
	output logic                 cpu_req_ready,
	output logic [31:0]          cpu_rsp_data,
	output logic                 cpu_rsp_valid,
	input  logic                 cpu_rsp_ready,

	output dcache_pkg::mem_req_t mem_rd_req,
	output logic                 mem_rd_req_valid,
	input  logic                 mem_rd_req_ready,
	input  logic                 mem_rd_rsp_valid,
	input  logic                 mem_rd_rsp_last,
	output logic                 mem_rd_rsp_ready,

	output dcache_pkg::mem_req_t mem_wr_req,
	output logic                 mem_wr_req_valid,
	input  logic                 mem_wr_req_ready,
	output logic                 mem_wr_data_valid,
	output logic                 mem_wr_data_last,
	input  logic                 mem_wr_data_ready,

	// Way store results for the current request.
	input  dcache_pkg::way_sel_t hit,
	input  logic                 victim_dirty,
	input  logic [`DC_TAG_W-1:0] victim_tag,
	input  logic [31:0]          hit_word,
	input  logic [31:0]          merged_word,
	input  logic                 beat_last,

	output dcache_pkg::cpu_req_t cur_req,
	output logic                 lookup_en,
	output logic                 write_hit_en,
	output logic                 fill_en,
	output logic                 buf_load,
	output logic                 buf_shift_in,
	output logic                 buf_shift_out
);

	dcache_pkg::cache_state_e state;
	dcache_pkg::cache_state_e state_next;
	dcache_pkg::cpu_req_t     req_q;
	logic [31:0]              rsp_q;
	logic                     req_ready_q;
	logic                     accept;
	logic                     is_hit;
	logic                     is_write;

	// Lookup uses the live request while idle, the held one after.
	assign cur_req = (state == dcache_pkg::idle) ? cpu_req : req_q;

	assign accept   = (state == dcache_pkg::idle) && cpu_req_valid && req_ready_q;
	assign is_hit   = |hit;
	assign is_write = (cur_req.op == dcache_pkg::op_write);

	// --------------------
	// Next state.
	always_comb begin
		state_next = state;
		case (state)
			dcache_pkg::idle: begin
				if (accept) begin
					if (is_hit)
						state_next = is_write ? dcache_pkg::lookup_done : dcache_pkg::respond;
					else if (victim_dirty)
						state_next = dcache_pkg::write_back_req;
					else
						state_next = dcache_pkg::refill_req;
				end
			end
			// One dead cycle after a write hit.
			dcache_pkg::lookup_done: state_next = dcache_pkg::idle;
			dcache_pkg::write_back_req: begin
				if (mem_wr_req_ready)
					state_next = dcache_pkg::write_back_data;
			end
			dcache_pkg::write_back_data: begin
				if (mem_wr_data_ready && beat_last)
					state_next = dcache_pkg::refill_req;
			end
			dcache_pkg::refill_req: begin
				if (mem_rd_req_ready)
					state_next = dcache_pkg::refill_data;
			end
			dcache_pkg::refill_data: begin
				if (mem_rd_rsp_valid && mem_rd_rsp_last)
					state_next = dcache_pkg::fill;
			end
			// Writes finish here, reads still owe a response.
			dcache_pkg::fill: state_next = is_write ? dcache_pkg::idle : dcache_pkg::respond;
			dcache_pkg::respond: begin
				if (cpu_rsp_ready)
					state_next = dcache_pkg::idle;
			end
			default: state_next = dcache_pkg::idle;
		endcase
	end

	// Ready follows the idle state one edge late, low through reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= dcache_pkg::idle;
			req_ready_q <= 1'b0;
		end else begin
			state       <= state_next;
			req_ready_q <= (state_next == dcache_pkg::idle);
		end
	end

	// Request held for the whole miss.
	always_ff @(posedge clk) begin
		if (accept)
			req_q <= cpu_req;
	end

	// Read data from a hit or from the refilled line.
	always_ff @(posedge clk) begin
		if (accept && is_hit && !is_write)
			rsp_q <= hit_word;
		else if (fill_en && !is_write)
			rsp_q <= merged_word;
	end

	// --------------------
	// Array and buffer strobes.
	assign lookup_en     = accept;
	assign write_hit_en  = accept && is_hit && is_write;
	assign buf_load      = accept && !is_hit;
	assign buf_shift_out = (state == dcache_pkg::write_back_data) && mem_wr_data_ready;
	assign buf_shift_in  = (state == dcache_pkg::refill_data) && mem_rd_rsp_valid;
	assign fill_en       = (state == dcache_pkg::fill);

	// CPU side.
	assign cpu_req_ready = req_ready_q;
	assign cpu_rsp_valid = (state == dcache_pkg::respond);
	assign cpu_rsp_data  = rsp_q;

	// Memory side. Victim line address for write-back.
	always_comb begin
		mem_wr_req.tag    = victim_tag;
		mem_wr_req.index  = req_q.addr.index;
		mem_wr_req.offset = '0;
		mem_rd_req.tag    = req_q.addr.tag;
		mem_rd_req.index  = req_q.addr.index;
		mem_rd_req.offset = '0;
	end

	assign mem_wr_req_valid  = (state == dcache_pkg::write_back_req);
	assign mem_wr_data_valid = (state == dcache_pkg::write_back_data);
	assign mem_wr_data_last  = mem_wr_data_valid && beat_last;
	assign mem_rd_req_valid  = (state == dcache_pkg::refill_req);
	assign mem_rd_rsp_ready  = (state == dcache_pkg::refill_data);

	// --------------------
	// Request and response never offered together.
	assert property (@(posedge clk) disable iff (rst)
		!(cpu_req_ready && cpu_rsp_valid));

	// Memory last beat lines up with the buffer's eighth beat.
	assert property (@(posedge clk) disable iff (rst)
		buf_shift_in |-> (mem_rd_rsp_last == beat_last));

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
	input  logic                 clk,
	input  logic                 rst,

	// CPU request and response.
	input  dcache_pkg::cpu_req_t cpu_req,
	input  logic                 cpu_req_valid,
	output logic                 cpu_req_ready,
	output logic [31:0]          cpu_rsp_data,
	output logic                 cpu_rsp_valid,
	input  logic                 cpu_rsp_ready,

	// Memory read burst.
	output dcache_pkg::mem_req_t mem_rd_req,
	output logic                 mem_rd_req_valid,
	input  logic                 mem_rd_req_ready,
	input  logic [31:0]          mem_rd_rsp_data,
	input  logic                 mem_rd_rsp_valid,
	input  logic                 mem_rd_rsp_last,
	output logic                 mem_rd_rsp_ready,

	// Memory write burst.
	output dcache_pkg::mem_req_t mem_wr_req,
	output logic                 mem_wr_req_valid,
	input  logic                 mem_wr_req_ready,
	output logic [31:0]          mem_wr_data,
	output logic                 mem_wr_data_valid,
	output logic                 mem_wr_data_last,
	input  logic                 mem_wr_data_ready
);

	// --------------------
	// Controller to way store.
	dcache_pkg::cpu_req_t cur_req;
	logic                 lookup_en;
	logic                 write_hit_en;
	logic                 fill_en;

	// Way store to controller.
	dcache_pkg::way_sel_t hit;
	logic                 victim_dirty;
	logic [`DC_TAG_W-1:0] victim_tag;
	logic [31:0]          hit_word;
	logic [31:0]          merged_word;
	dcache_pkg::line_t    sel_line;

	// Line buffer strobes and state.
	logic                 buf_load;
	logic                 buf_shift_in;
	logic                 buf_shift_out;
	logic                 beat_last;
	dcache_pkg::line_t    fill_line;

	// --------------------
	dcache_ctrl ctrl_i (
		.clk               (clk),
		.rst               (rst),
		.cpu_req           (cpu_req),
		.cpu_req_valid     (cpu_req_valid),
		.cpu_req_ready     (cpu_req_ready),
		.cpu_rsp_data      (cpu_rsp_data),
		.cpu_rsp_valid     (cpu_rsp_valid),
		.cpu_rsp_ready     (cpu_rsp_ready),
		.mem_rd_req        (mem_rd_req),
		.mem_rd_req_valid  (mem_rd_req_valid),
		.mem_rd_req_ready  (mem_rd_req_ready),
		.mem_rd_rsp_valid  (mem_rd_rsp_valid),
		.mem_rd_rsp_last   (mem_rd_rsp_last),
		.mem_rd_rsp_ready  (mem_rd_rsp_ready),
		.mem_wr_req        (mem_wr_req),
		.mem_wr_req_valid  (mem_wr_req_valid),
		.mem_wr_req_ready  (mem_wr_req_ready),
		.mem_wr_data_valid (mem_wr_data_valid),
		.mem_wr_data_last  (mem_wr_data_last),
		.mem_wr_data_ready (mem_wr_data_ready),
		.hit               (hit),
		.victim_dirty      (victim_dirty),
		.victim_tag        (victim_tag),
		.hit_word          (hit_word),
		.merged_word       (merged_word),
		.beat_last         (beat_last),
		.cur_req           (cur_req),
		.lookup_en         (lookup_en),
		.write_hit_en      (write_hit_en),
		.fill_en           (fill_en),
		.buf_load          (buf_load),
		.buf_shift_in      (buf_shift_in),
		.buf_shift_out     (buf_shift_out)
	);

	dcache_ways ways_i (
		.clk          (clk),
		.rst          (rst),
		.req          (cur_req),
		.lookup_en    (lookup_en),
		.write_hit_en (write_hit_en),
		.fill_en      (fill_en),
		.fill_line    (fill_line),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.hit_word     (hit_word),
		.merged_word  (merged_word),
		.sel_line     (sel_line)
	);

	// Write-back beats go straight out of the buffer.
	line_buffer buf_i (
		.clk       (clk),
		.rst       (rst),
		.load_line (sel_line),
		.buf_load  (buf_load),
		.shift_in  (buf_shift_in),
		.in_word   (mem_rd_rsp_data),
		.shift_out (buf_shift_out),
		.line      (fill_line),
		.out_word  (mem_wr_data),
		.beat_last (beat_last)
	);

endmodule

// File: testbench/dcache_mem_model.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_mem_model (
	input  logic                 clk,
	input  logic                 rst,
	input  dcache_pkg::mem_req_t mem_rd_req,
	input  logic                 mem_rd_req_valid,
	output logic                 mem_rd_req_ready,
	output logic [31:0]          mem_rd_rsp_data,
	output logic                 mem_rd_rsp_valid,
	output logic                 mem_rd_rsp_last,
	input  logic                 mem_rd_rsp_ready,
	input  dcache_pkg::mem_req_t mem_wr_req,
	input  logic                 mem_wr_req_valid,
	output logic                 mem_wr_req_ready,
	input  logic [31:0]          mem_wr_data,
	input  logic                 mem_wr_data_valid,
	output logic                 mem_wr_data_ready
);

	// Sparse word store where untouched words follow a fill pattern.
	logic [31:0] store [logic [31:0]];
	integer      seed;
	logic        rd_active;
	logic [31:0] rd_addr;
	int          rd_beat;
	logic [31:0] wr_addr;
	int          wr_beat;
	logic        rd_req_fire;
	logic        rd_beat_fire;
	logic        wr_req_fire;

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (store.exists(addr))
			return store[addr];
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a96e1;
	endfunction

	initial begin
		seed              = 32'hc511;
		rd_active         = 1'b0;
		rd_addr           = '0;
		rd_beat           = 0;
		wr_addr           = '0;
		wr_beat           = 0;
		mem_rd_req_ready  = 1'b0;
		mem_rd_rsp_data   = '0;
		mem_rd_rsp_valid  = 1'b0;
		mem_rd_rsp_last   = 1'b0;
		mem_wr_req_ready  = 1'b0;
		mem_wr_data_ready = 1'b0;
		forever begin
			// Handshakes seen mid cycle complete at the next edge.
			@(negedge clk);
			rd_req_fire  = mem_rd_req_valid && mem_rd_req_ready;
			rd_beat_fire = mem_rd_rsp_valid && mem_rd_rsp_ready;
			wr_req_fire  = mem_wr_req_valid && mem_wr_req_ready;
			if (mem_wr_data_valid && mem_wr_data_ready) begin
				store[wr_addr + 32'(4 * wr_beat)] = mem_wr_data;
				wr_beat++;
			end
			@(posedge clk);
			#1;
			if (wr_req_fire) begin
				wr_addr = mem_wr_req;
				wr_beat = 0;
			end
			if (rd_req_fire) begin
				rd_active = 1'b1;
				rd_addr   = mem_rd_req;
				rd_beat   = 0;
			end
			if (rd_beat_fire) begin
				rd_beat++;
				if (rd_beat == `DC_BEATS)
					rd_active = 1'b0;
			end
			if (rst)
				rd_active = 1'b0;
			// A raised valid holds until its beat is taken.
			if (!(mem_rd_rsp_valid && !rd_beat_fire))
				mem_rd_rsp_valid = rd_active && (($random(seed) & 3) != 0);
			mem_rd_rsp_data   = read_word(rd_addr + 32'(4 * rd_beat));
			mem_rd_rsp_last   = (rd_beat == `DC_BEATS - 1);
			mem_rd_req_ready  = (($random(seed) & 3) != 0);
			mem_wr_req_ready  = (($random(seed) & 3) != 0);
			mem_wr_data_ready = (($random(seed) & 3) != 0);
		end
	end

endmodule

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;

	localparam int NUM_REQ = 2000;
	localparam int TIMEOUT = 500;

	logic                 clk;
	logic                 rst;
	dcache_pkg::cpu_req_t cpu_req;
	logic                 cpu_req_valid;
	logic                 cpu_req_ready;
	logic [31:0]          cpu_rsp_data;
	logic                 cpu_rsp_valid;
	logic                 cpu_rsp_ready;
	dcache_pkg::mem_req_t mem_rd_req;
	logic                 mem_rd_req_valid;
	logic                 mem_rd_req_ready;
	logic [31:0]          mem_rd_rsp_data;
	logic                 mem_rd_rsp_valid;
	logic                 mem_rd_rsp_last;
	logic                 mem_rd_rsp_ready;
	dcache_pkg::mem_req_t mem_wr_req;
	logic                 mem_wr_req_valid;
	logic                 mem_wr_req_ready;
	logic [31:0]          mem_wr_data;
	logic                 mem_wr_data_valid;
	logic                 mem_wr_data_last;
	logic                 mem_wr_data_ready;

	dcache_top dut_i (.*);
	dcache_mem_model mem_i (.*);

	// --------------------
	// Reference model of flat memory plus tag and age state.
	logic [31:0]          ref_mem [logic [31:0]];
	logic [`DC_TAG_W-1:0] m_tag   [`DC_SETS][`DC_WAYS];
	logic                 m_valid [`DC_SETS][`DC_WAYS];
	logic                 m_dirty [`DC_SETS][`DC_WAYS];
	int                   m_age   [`DC_SETS][`DC_WAYS];

	integer      seed;
	logic        monitor_on;
	logic        exp_miss;
	logic        exp_wb;
	logic        cur_write;
	logic [31:0] exp_rd_addr;
	logic [31:0] exp_wb_addr;
	int          rd_seen;
	int          wb_seen;
	int          wb_beat;
	logic        rd_burst;

	// Monitor state from the previous mid-cycle sample.
	logic        hold_rsp;
	logic        hold_rd;
	logic        hold_wr;
	logic        hold_wd;
	logic [31:0] prev_rsp;
	logic [31:0] prev_rd;
	logic [31:0] prev_wr;
	logic [31:0] prev_wd;
	logic        prev_wlast;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic die(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			die($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		if (ref_mem.exists(addr))
			return ref_mem[addr];
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a96e1;
	endfunction

	// --------------------
	// Bus monitor sampled mid cycle once all signals settle.
	always @(negedge clk) begin
		if (monitor_on) begin
			// Payloads stay put while stalled.
			if (hold_rsp)
				check_value("cpu_rsp_data", cpu_rsp_data, prev_rsp);
			if (hold_rd)
				check_value("mem_rd_req", mem_rd_req, prev_rd);
			if (hold_wr)
				check_value("mem_wr_req", mem_wr_req, prev_wr);
			if (hold_wd) begin
				check_value("mem_wr_data", mem_wr_data, prev_wd);
				check_value("mem_wr_data_last", 32'(mem_wr_data_last), 32'(prev_wlast));
			end
			if (cpu_rsp_valid && cur_write)
				die("A response appeared for a write request.");
			// Refill beats are accepted for the whole read burst.
			check_value("mem_rd_rsp_ready", 32'(mem_rd_rsp_ready), 32'(rd_burst));
			if (mem_rd_req_valid && mem_rd_req_ready) begin
				check_value("mem_rd_req_valid", 32'(1'b1), 32'(exp_miss));
				check_value("mem_rd_req", mem_rd_req, exp_rd_addr);
				rd_seen++;
				rd_burst = 1'b1;
			end
			if (mem_rd_rsp_valid && mem_rd_rsp_ready && mem_rd_rsp_last)
				rd_burst = 1'b0;
			if (mem_wr_req_valid && mem_wr_req_ready) begin
				check_value("mem_wr_req_valid", 32'(1'b1), 32'(exp_wb));
				check_value("mem_wr_req", mem_wr_req, exp_wb_addr);
				wb_seen++;
			end
			if (mem_wr_data_valid && mem_wr_data_ready) begin
				check_value("mem_wr_data", mem_wr_data,
					ref_read(exp_wb_addr + 32'(4 * wb_beat)));
				check_value("mem_wr_data_last", 32'(mem_wr_data_last),
					32'(wb_beat == `DC_BEATS - 1));
				wb_beat++;
			end
		end
		hold_rsp   = cpu_rsp_valid && !cpu_rsp_ready;
		hold_rd    = mem_rd_req_valid && !mem_rd_req_ready;
		hold_wr    = mem_wr_req_valid && !mem_wr_req_ready;
		hold_wd    = mem_wr_data_valid && !mem_wr_data_ready;
		prev_rsp   = cpu_rsp_data;
		prev_rd    = mem_rd_req;
		prev_wr    = mem_wr_req;
		prev_wd    = mem_wr_data;
		prev_wlast = mem_wr_data_last;
	end

	// --------------------
	// Predicts, drives and checks one random request to completion.
	task automatic run_request();
		logic [`DC_TAG_W-1:0]   tag;
		logic [`DC_INDEX_W-1:0] idx;
		logic [2:0]             word;
		logic [31:0]            addr;
		logic [31:0]            wdata;
		logic [31:0]            old_word;
		logic [3:0]             strb;
		logic                   is_write;
		logic                   done;
		int                     hit_way;
		int                     victim;
		int                     target;
		int                     t_age;
		int                     wait_cnt;
		tag      = 24'h00a100 + 24'(($random(seed) & 32'h7fff_ffff) % 6) * 24'h000b35;
		idx      = 3'($random(seed));
		word     = 3'($random(seed));
		addr     = {tag, idx, word, 2'b00};
		is_write = 1'($random(seed));
		wdata    = $random(seed);
		strb     = 4'($random(seed));

		// Model lookup.
		hit_way = -1;
		victim  = -1;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag)
				hit_way = w;
			if (victim < 0 && m_age[idx][w] == `DC_WAYS - 1)
				victim = w;
		end
		exp_miss    = (hit_way < 0);
		exp_wb      = exp_miss && m_dirty[idx][victim] && m_valid[idx][victim];
		exp_rd_addr = {tag, idx, 5'd0};
		exp_wb_addr = {m_tag[idx][victim], idx, 5'd0};
		rd_seen     = 0;
		wb_seen     = 0;
		wb_beat     = 0;
		cur_write   = is_write;

		repeat (($random(seed) & 32'h7fff_ffff) % 3) begin
			@(posedge clk);
			#1;
		end
		cpu_req.op    = is_write ? dcache_pkg::op_write : dcache_pkg::op_read;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cpu_req.strb  = strb;
		cpu_req_valid = 1'b1;
		wait_cnt      = 0;
		@(negedge clk);
		while (!cpu_req_ready) begin
			wait_cnt++;
			if (wait_cnt > TIMEOUT)
				die("Timed out waiting for cpu_req_ready.");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		cpu_req_valid = 1'b0;

		// Architectural write with strobes.
		if (is_write) begin
			old_word = ref_read(addr);
			for (int b = 0; b < 4; b++)
				if (strb[b])
					old_word[8*b +: 8] = wdata[8*b +: 8];
			ref_mem[addr] = old_word;
		end

		// Age rule on the target way, then the tag state.
		target = exp_miss ? victim : hit_way;
		t_age  = m_age[idx][target];
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (w == target)
				m_age[idx][w] = 0;
			else if (m_age[idx][w] < t_age)
				m_age[idx][w]++;
		end
		if (exp_miss) begin
			m_tag[idx][target]   = tag;
			m_valid[idx][target] = 1'b1;
			m_dirty[idx][target] = is_write;
		end else if (is_write) begin
			m_dirty[idx][target] = 1'b1;
		end

		if (!is_write) begin
			done     = 1'b0;
			wait_cnt = 0;
			while (!done) begin
				cpu_rsp_ready = ($random(seed) & 3) != 0;
				@(negedge clk);
				if (cpu_rsp_valid && cpu_rsp_ready) begin
					check_value("cpu_rsp_data", cpu_rsp_data, ref_read(addr));
					done = 1'b1;
				end else begin
					wait_cnt++;
					if (wait_cnt > TIMEOUT)
						die("Timed out waiting for a read response.");
				end
				@(posedge clk);
				#1;
			end
			cpu_rsp_ready = 1'b0;
		end else if (!exp_miss) begin
			// Write hit drops ready for one cycle only.
			@(negedge clk);
			check_value("cpu_req_ready", 32'(cpu_req_ready), 32'(1'b0));
			@(negedge clk);
			check_value("cpu_req_ready", 32'(cpu_req_ready), 32'(1'b1));
			@(posedge clk);
			#1;
		end else begin
			wait_cnt = 0;
			@(negedge clk);
			while (!cpu_req_ready) begin
				wait_cnt++;
				if (wait_cnt > TIMEOUT)
					die("Timed out waiting for a write miss to finish.");
				@(negedge clk);
			end
			@(posedge clk);
			#1;
		end
		check_value("mem_rd_req count", rd_seen, 32'(exp_miss));
		check_value("mem_wr_req count", wb_seen, 32'(exp_wb));
		check_value("mem_wr_data beats", wb_beat, exp_wb ? `DC_BEATS : 0);
	endtask

	// --------------------
	initial begin
		seed          = 32'hc511;
		monitor_on    = 1'b0;
		cur_write     = 1'b0;
		rd_burst      = 1'b0;
		rst           = 1'b1;
		cpu_req       = '0;
		cpu_req_valid = 1'b0;
		cpu_rsp_ready = 1'b0;
		for (int s = 0; s < `DC_SETS; s++)
			for (int w = 0; w < `DC_WAYS; w++) begin
				m_tag[s][w]   = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_age[s][w]   = w;
			end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// First cycle out of reset.
		@(posedge clk);
		@(negedge clk);
		check_value("cpu_req_ready", 32'(cpu_req_ready), 32'(1'b1));
		check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'(1'b0));
		check_value("mem_rd_req_valid", 32'(mem_rd_req_valid), 32'(1'b0));
		check_value("mem_wr_req_valid", 32'(mem_wr_req_valid), 32'(1'b0));
		check_value("mem_wr_data_valid", 32'(mem_wr_data_valid), 32'(1'b0));
		monitor_on = 1'b1;
		@(posedge clk);
		#1;
		for (int n = 0; n < NUM_REQ; n++)
			run_request();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: compile.f
+incdir+logic
logic/dcache_pkg.sv
logic/line_buffer.sv
logic/dcache_ways.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.
verilator --binary --timing --assert --top-module dcache_tb -f compile.f -o dcache_sim \
	&& ./obj_dir/dcache_sim \
	|| { echo "simulation failed"; exit 1; }
